/* bench/spmm_checker.sv */
`default_nettype none

module spmm_checker (
    input logic                              clock,
    input logic                              reset,
    input logic                              rhs_valid,
    input spmm_pkg::beat_t                   rhs_rows,
    input logic                              rhs_ready,
    input logic                              lhs_valid,
    input spmm_pkg::ptr_t [spmm_pkg::n-1:0]  lhs_row_end,
    input spmm_pkg::idx_t [spmm_pkg::n-1:0]  lhs_col,
    input spmm_pkg::data_t [spmm_pkg::n-1:0] lhs_data,
    input logic                              lhs_ready,
    input logic                              out_valid,
    input spmm_pkg::beat_t                   out_rows,
    input logic                              out_last,
    input logic                              out_ready
);

    localparam int last_beat = spmm_pkg::beats_per_matrix - 1;
    localparam int first_beat_delay = spmm_pkg::pipe_depth + 1;

    int error_count = 0;
    int job_count = 0;
    int beat_count = 0;

    spmm_pkg::matrix_t b_model;
    spmm_pkg::matrix_t expected;
    spmm_pkg::beat_t   held_rows;
    int                rhs_beat;
    int                out_beat;
    int                edges;
    int                row;
    logic              busy;
    logic              seen_valid;
    logic              stalled;

    task automatic note_error(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    // C[r][j] is the wrapped sum of data * B[col][j] over row r's nonzeros
    function automatic spmm_pkg::matrix_t reference_product(
        input spmm_pkg::ptr_t [spmm_pkg::n-1:0]  row_end,
        input spmm_pkg::idx_t [spmm_pkg::n-1:0]  col,
        input spmm_pkg::data_t [spmm_pkg::n-1:0] data,
        input spmm_pkg::matrix_t                 b
    );
        spmm_pkg::matrix_t c;
        int                start;
        c = '0;
        start = 0;
        for (int r = 0; r < spmm_pkg::n; r++) begin
            for (int k = start; k < int'(row_end[r]); k++) begin
                for (int j = 0; j < spmm_pkg::n; j++) begin
                    c[r][j] = c[r][j] + data[k] * b[col[k]][j];
                end
            end
            start = int'(row_end[r]);
        end
        return c;
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            b_model = '0;
            rhs_beat = 0;
            out_beat = 0;
            edges = 0;
            busy = 1'b0;
            seen_valid = 1'b0;
            stalled = 1'b0;
        end else begin
            if (rhs_valid && rhs_ready) begin
                for (int k = 0; k < spmm_pkg::rows_per_beat; k++) begin
                    b_model[rhs_beat * spmm_pkg::rows_per_beat + k] = rhs_rows[k];
                end
                rhs_beat = (rhs_beat + 1) % spmm_pkg::beats_per_matrix;
            end
            // handshake levels against the job in flight
            if (busy && lhs_ready !== 1'b0) begin
                note_error($sformatf("Mismatch lhs_ready job %0d: got %h expected %h",
                                     job_count, lhs_ready, 1'b0));
            end
            if (busy && rhs_ready !== 1'b0) begin
                note_error($sformatf("Mismatch rhs_ready job %0d: got %h expected %h",
                                     job_count, rhs_ready, 1'b0));
            end
            if (!busy && !(lhs_valid && lhs_ready) && rhs_ready !== 1'b1) begin
                note_error($sformatf("Mismatch rhs_ready between jobs: got %h expected %h",
                                     rhs_ready, 1'b1));
            end
            if (!busy && out_valid !== 1'b0) begin
                note_error($sformatf("Mismatch out_valid between jobs: got %h expected %h",
                                     out_valid, 1'b0));
            end
            // latency of the first output beat
            if (busy && !seen_valid) begin
                if (out_valid) begin
                    if (edges != first_beat_delay) begin
                        note_error($sformatf("first beat came %0d edges after acceptance, not %0d",
                                             edges, first_beat_delay));
                    end
                    seen_valid = 1'b1;
                end
                edges++;
            end
            if (stalled && out_valid && (out_rows !== held_rows)) begin
                note_error($sformatf("Mismatch out_rows during stall: got %h expected %h",
                                     out_rows, held_rows));
            end
            if (out_valid && out_ready && busy) begin
                for (int k = 0; k < spmm_pkg::rows_per_beat; k++) begin
                    row = out_beat * spmm_pkg::rows_per_beat + k;
                    if (out_rows[k] !== expected[row]) begin
                        note_error($sformatf(
                            "Mismatch out_rows[%0d] job %0d row %0d: got %h expected %h",
                            k, job_count, row, out_rows[k], expected[row]));
                    end
                end
                if (out_last !== (out_beat == last_beat)) begin
                    note_error($sformatf("Mismatch out_last job %0d beat %0d: got %h expected %h",
                                         job_count, out_beat, out_last, out_beat == last_beat));
                end
                beat_count++;
                if (out_beat == last_beat) begin
                    busy = 1'b0;
                    out_beat = 0;
                end else begin
                    out_beat++;
                end
            end
            stalled = out_valid && !out_ready;
            held_rows = out_rows;
            if (lhs_valid && lhs_ready) begin
                expected = reference_product(lhs_row_end, lhs_col, lhs_data, b_model);
                busy = 1'b1;
                seen_valid = 1'b0;
                edges = 0;
                job_count++;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/spmm_sva.sv */
`default_nettype none

module spmm_sva (
    input logic           clock,
    input logic           reset,
    input logic           rhs_valid,
    input logic           rhs_ready,
    input spmm_pkg::idx_t rhs_beat,
    input logic           lhs_ready,
    input logic           out_valid,
    input logic           out_ready,
    input logic           out_last
);

    int failure_count = 0;

    // a product beat holds until it is taken
    out_hold: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid)
        else begin
            failure_count = failure_count + 1;
            $error("out_valid dropped before out_ready");
        end

    // quiet cycle after the final beat before the next job
    no_overlap: assert property (@(posedge clock) disable iff (reset)
        out_valid && out_ready && out_last |=> !out_valid && !lhs_ready)
        else begin
            failure_count = failure_count + 1;
            $error("lhs_ready or out_valid high right after the final beat");
        end

    // a partial load leaves no complete right operand
    rhs_gate: assert property (@(posedge clock) disable iff (reset)
        rhs_valid && rhs_ready &&
        (rhs_beat != spmm_pkg::idx_t'(spmm_pkg::beats_per_matrix - 1)) |=> !lhs_ready)
        else begin
            failure_count = failure_count + 1;
            $error("lhs_ready high after a partial right operand load");
        end

endmodule

bind spmm_ctrl spmm_sva sva0 (
    .clock     (clock),
    .reset     (reset),
    .rhs_valid (rhs_valid),
    .rhs_ready (rhs_ready),
    .rhs_beat  (rhs_beat),
    .lhs_ready (lhs_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last)
);

`default_nettype wire

/* bench/spmm_tb.sv */
`default_nettype none

module spmm_tb;

    localparam int clock_period = 100;
    localparam int reset_cycles = 4;
    localparam int job_total = 40;
    localparam int cycles_per_job = 20;
    localparam int timeout = job_total * cycles_per_job * clock_period;

    logic                              clock;
    logic                              reset;
    logic                              rhs_valid;
    spmm_pkg::beat_t                   rhs_rows;
    logic                              rhs_ready;
    logic                              lhs_valid;
    spmm_pkg::ptr_t [spmm_pkg::n-1:0]  lhs_row_end;
    spmm_pkg::idx_t [spmm_pkg::n-1:0]  lhs_col;
    spmm_pkg::data_t [spmm_pkg::n-1:0] lhs_data;
    logic                              lhs_ready;
    logic                              out_valid;
    spmm_pkg::beat_t                   out_rows;
    logic                              out_last;
    logic                              out_ready;

    int seed;
    int stall_seed;
    int jobs_done;

    spmm_top dut0 (
        .clock       (clock),
        .reset       (reset),
        .rhs_valid   (rhs_valid),
        .rhs_rows    (rhs_rows),
        .rhs_ready   (rhs_ready),
        .lhs_valid   (lhs_valid),
        .lhs_row_end (lhs_row_end),
        .lhs_col     (lhs_col),
        .lhs_data    (lhs_data),
        .lhs_ready   (lhs_ready),
        .out_valid   (out_valid),
        .out_rows    (out_rows),
        .out_last    (out_last),
        .out_ready   (out_ready)
    );

    // watches the same nets by name
    spmm_checker chk0 (.*);

    always #(clock_period / 2) clock = ~clock;

    // random output back-pressure, about one stall in four
    always @(posedge clock) begin
        #1;
        out_ready = (($random(stall_seed) & 3) != 0);
    end

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic send_rhs_beat();
        for (int k = 0; k < spmm_pkg::rows_per_beat; k++) begin
            for (int c = 0; c < spmm_pkg::n; c++) begin
                rhs_rows[k][c] = $random(seed);
            end
        end
        rhs_valid = 1'b1;
        do begin
            @(posedge clock);
        end while (!rhs_ready);
        #1;
        rhs_valid = 1'b0;
    endtask

    task automatic load_rhs();
        repeat (spmm_pkg::beats_per_matrix) send_rhs_beat();
    endtask

    // mode 0 full, 1 one row, 2 fewer than n, 3 no nonzeros
    task automatic make_job(input int mode);
        int count [spmm_pkg::n];
        int nnz;
        int one_row;
        int total;
        case (mode)
            0: nnz = spmm_pkg::n;
            1: nnz = 1 + {$random(seed)} % spmm_pkg::n;
            2: nnz = {$random(seed)} % spmm_pkg::n;
            default: nnz = 0;
        endcase
        one_row = {$random(seed)} % spmm_pkg::n;
        for (int r = 0; r < spmm_pkg::n; r++) begin
            count[r] = 0;
        end
        for (int k = 0; k < nnz; k++) begin
            if (mode == 1) begin
                count[one_row]++;
            end else begin
                count[{$random(seed)} % spmm_pkg::n]++;
            end
        end
        total = 0;
        for (int r = 0; r < spmm_pkg::n; r++) begin
            total += count[r];
            lhs_row_end[r] = spmm_pkg::ptr_t'(total);
        end
        // padding positions get random values too
        for (int k = 0; k < spmm_pkg::n; k++) begin
            lhs_col[k] = spmm_pkg::idx_t'($random(seed));
            lhs_data[k] = spmm_pkg::data_t'($random(seed));
        end
    endtask

    task automatic run_job();
        lhs_valid = 1'b1;
        do begin
            @(posedge clock);
        end while (!lhs_ready);
        #1;
        lhs_valid = 1'b0;
        lhs_data = ~lhs_data;
        do begin
            @(posedge clock);
        end while (!(out_valid && out_ready && out_last));
        #1;
        jobs_done++;
    endtask

    // job waits on lhs_valid while the reload is still partial
    task automatic reload_with_waiting_job(input int mode);
        repeat (spmm_pkg::beats_per_matrix - 1) send_rhs_beat();
        make_job(mode);
        lhs_valid = 1'b1;
        send_rhs_beat();
        run_job();
    endtask

    initial begin
        #(timeout);
        $display("watchdog expired at %0d units: jobs=%0d of %0d, errors=%0d",
                 timeout, jobs_done, job_total, chk0.error_count);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed = 78;
        stall_seed = 78;
        jobs_done = 0;
        clock = 1'b0;
        reset = 1'b1;
        rhs_valid = 1'b0;
        rhs_rows = '0;
        lhs_valid = 1'b0;
        lhs_row_end = '0;
        lhs_col = '0;
        lhs_data = '0;
        out_ready = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
        load_rhs();
        for (int mode = 0; mode < 4; mode++) begin
            make_job(mode);
            run_job();
        end
        for (int i = 4; i < job_total; i++) begin
            if (i % 6 == 0) begin
                reload_with_waiting_job({$random(seed)} % 3);
            end else begin
                if (i % 6 == 3) begin
                    load_rhs();
                end
                make_job({$random(seed)} % 3);
                run_job();
            end
            idle_cycles({$random(seed)} % 2);
        end
        idle_cycles(2);
        $display("jobs=%0d beats=%0d checker errors=%0d assertion failures=%0d",
                 chk0.job_count, chk0.beat_count, chk0.error_count,
                 dut0.ctrl0.sva0.failure_count);
        if (chk0.error_count == 0 && dut0.ctrl0.sva0.failure_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* spmm.f */
src/spmm_pkg.sv
src/lhs_job_if.sv
src/spmm_ctrl.sv
src/rhs_store.sv
src/segment_decoder.sv
src/pe_column.sv
src/result_drain.sv
src/spmm_top.sv
bench/spmm_sva.sv
bench/spmm_checker.sv
bench/spmm_tb.sv

/* src/lhs_job_if.sv */
`default_nettype none

interface lhs_job_if;

    // one-cycle pulse, decoded fields valid from here on
    logic issue;

    // row of each nonzero position, n marks padding
    spmm_pkg::ptr_t [spmm_pkg::n-1:0] row_id;

    spmm_pkg::idx_t [spmm_pkg::n-1:0] col;
    spmm_pkg::data_t [spmm_pkg::n-1:0] data;

    // per row: position of last nonzero and whether the row has any
    spmm_pkg::idx_t [spmm_pkg::n-1:0] row_last;
    logic [spmm_pkg::n-1:0] row_nonempty;

    modport source (output issue, row_id, col, data, row_last, row_nonempty);

    modport sink (input issue, row_id, col, data, row_last, row_nonempty);

endinterface

`default_nettype wire

/* src/pe_column.sv */
`default_nettype none

module pe_column #(
    parameter int col_index = 0
) (
    input  logic              clock,
    input  logic              reset,
    lhs_job_if.sink           job,
    input  spmm_pkg::matrix_t matrix,
    output spmm_pkg::row_t    row_sums
);

    // stage 0 holds products, stage red_levels holds segmented prefix sums
    spmm_pkg::data_t [spmm_pkg::n-1:0] sum_q [spmm_pkg::red_levels+1];

    // row ids travel alongside the values
    spmm_pkg::ptr_t [spmm_pkg::n-1:0]  id_q [spmm_pkg::red_levels];

    always_ff @(posedge clock) begin
        if (job.issue) begin
            for (int i = 0; i < spmm_pkg::n; i++) begin
                sum_q[0][i] <= job.data[i] * matrix[job.col[i]][col_index];
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < spmm_pkg::n; i++) begin
                id_q[0][i] <= spmm_pkg::ptr_t'(spmm_pkg::n);
            end
        end else if (job.issue) begin
            id_q[0] <= job.row_id;
        end
    end

    for (genvar s = 0; s < spmm_pkg::red_levels; s++) begin : g_stage
        // add the value 2^s back only when it belongs to the same row
        always_ff @(posedge clock) begin
            for (int i = 0; i < (1 << s); i++) begin
                sum_q[s+1][i] <= sum_q[s][i];
            end
            for (int i = (1 << s); i < spmm_pkg::n; i++) begin
                if (id_q[s][i - (1 << s)] == id_q[s][i]) begin
                    sum_q[s+1][i] <= sum_q[s][i] + sum_q[s][i - (1 << s)];
                end else begin
                    sum_q[s+1][i] <= sum_q[s][i];
                end
            end
        end

        if (s + 1 < spmm_pkg::red_levels) begin : g_id
            always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                    for (int i = 0; i < spmm_pkg::n; i++) begin
                        id_q[s+1][i] <= spmm_pkg::ptr_t'(spmm_pkg::n);
                    end
                end else begin
                    id_q[s+1] <= id_q[s];
                end
            end
        end
    end

    // row total sits at its last nonzero
    always_comb begin
        for (int r = 0; r < spmm_pkg::n; r++) begin
            if (job.row_nonempty[r]) begin
                row_sums[r] = sum_q[spmm_pkg::red_levels][job.row_last[r]];
            end else begin
                row_sums[r] = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/result_drain.sv */
`default_nettype none

module result_drain (
    input  logic              clock,
    input  logic              reset,
    input  logic              capture,
    input  spmm_pkg::idx_t    out_beat,
    // entry j is the row sums of result column j
    input  spmm_pkg::matrix_t row_sums,
    output spmm_pkg::beat_t   out_rows
);

    spmm_pkg::matrix_t product;
    int                base_row;

    // transpose column sums into row-major product
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            product <= '0;
        end else if (capture) begin
            for (int r = 0; r < spmm_pkg::n; r++) begin
                for (int j = 0; j < spmm_pkg::n; j++) begin
                    product[r][j] <= row_sums[j][r];
                end
            end
        end
    end

    assign base_row = int'(out_beat) * spmm_pkg::rows_per_beat;

    always_comb begin
        for (int k = 0; k < spmm_pkg::rows_per_beat; k++) begin
            out_rows[k] = product[base_row + k];
        end
    end

endmodule

`default_nettype wire

/* src/rhs_store.sv */
`default_nettype none

module rhs_store (
    input  logic              clock,
    input  logic              reset,
    input  logic              rhs_write,
    input  spmm_pkg::idx_t    rhs_beat,
    input  spmm_pkg::beat_t   rhs_rows,
    output spmm_pkg::matrix_t matrix
);

    // first row written by the current beat
    int base_row;

    assign base_row = int'(rhs_beat) * spmm_pkg::rows_per_beat;

    // beat b fills rows 4b to 4b+3
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            matrix <= '0;
        end else if (rhs_write) begin
            for (int k = 0; k < spmm_pkg::rows_per_beat; k++) begin
                matrix[base_row + k] <= rhs_rows[k];
            end
        end
    end

endmodule

`default_nettype wire

/* src/segment_decoder.sv */
`default_nettype none

module segment_decoder (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  job_load,
    input  spmm_pkg::ptr_t [spmm_pkg::n-1:0]      lhs_row_end,
    input  spmm_pkg::idx_t [spmm_pkg::n-1:0]      lhs_col,
    input  spmm_pkg::data_t [spmm_pkg::n-1:0]     lhs_data,
    lhs_job_if.source                             job
);

    spmm_pkg::ptr_t [spmm_pkg::n-1:0]  row_end_q;
    spmm_pkg::idx_t [spmm_pkg::n-1:0]  col_q;
    spmm_pkg::data_t [spmm_pkg::n-1:0] data_q;
    logic                              loaded;

    spmm_pkg::ptr_t [spmm_pkg::n-1:0]  row_id_d;
    spmm_pkg::idx_t [spmm_pkg::n-1:0]  row_last_d;
    logic [spmm_pkg::n-1:0]            row_nonempty_d;

    // capture the sparse operand on acceptance
    always_ff @(posedge clock) begin
        if (job_load) begin
            row_end_q <= lhs_row_end;
            col_q <= lhs_col;
            data_q <= lhs_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            loaded <= 1'b0;
            job.issue <= 1'b0;
        end else begin
            loaded <= job_load;
            job.issue <= loaded;
        end
    end

    always_comb begin
        // row of position p = number of row ends at or below p
        for (int p = 0; p < spmm_pkg::n; p++) begin
            row_id_d[p] = '0;
            for (int r = 0; r < spmm_pkg::n; r++) begin
                if (row_end_q[r] <= spmm_pkg::ptr_t'(p)) begin
                    row_id_d[p] = row_id_d[p] + 1'b1;
                end
            end
        end
        for (int r = 0; r < spmm_pkg::n; r++) begin
            row_last_d[r] = spmm_pkg::idx_t'(row_end_q[r] - 1'b1);
        end
        row_nonempty_d[0] = (row_end_q[0] != '0);
        for (int r = 1; r < spmm_pkg::n; r++) begin
            row_nonempty_d[r] = (row_end_q[r] != row_end_q[r-1]);
        end
    end

    always_ff @(posedge clock) begin
        if (loaded) begin
            job.row_id <= row_id_d;
            job.row_last <= row_last_d;
            job.row_nonempty <= row_nonempty_d;
        end
    end

    // held stable in the capture registers until the next job
    assign job.col = col_q;
    assign job.data = data_q;

endmodule

`default_nettype wire

/* src/spmm_ctrl.sv */
`default_nettype none

module spmm_ctrl (
    input  logic           clock,
    input  logic           reset,
    input  logic           rhs_valid,
    input  logic           lhs_valid,
    input  logic           out_ready,
    output logic           rhs_ready,
    output logic           lhs_ready,
    output logic           out_valid,
    output logic           out_last,
    output logic           rhs_write,
    output spmm_pkg::idx_t rhs_beat,
    output logic           job_load,
    output logic           capture,
    output spmm_pkg::idx_t out_beat
);

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_drain
    } state_t;

    typedef logic [$clog2(spmm_pkg::pipe_depth + 1)-1:0] count_t;

    state_t state;
    count_t compute_count;
    logic   rhs_complete;
    logic   drain_done;

    // one idle cycle after the final beat before the next job
    assign lhs_ready = (state == st_idle) && rhs_complete && !drain_done;
    assign job_load = lhs_valid && lhs_ready;

    // a job accepted this cycle wins over a new rhs beat
    assign rhs_ready = (state == st_idle) && !job_load;
    assign rhs_write = rhs_valid && rhs_ready;

    assign capture = (state == st_compute) &&
                     (compute_count == count_t'(spmm_pkg::pipe_depth));

    assign out_valid = (state == st_drain);
    assign out_last = out_valid &&
                      (out_beat == spmm_pkg::idx_t'(spmm_pkg::beats_per_matrix - 1));

    // rhs beat counter, complete only after the final beat of a load
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rhs_beat <= '0;
            rhs_complete <= 1'b0;
        end else if (rhs_write) begin
            if (rhs_beat == spmm_pkg::idx_t'(spmm_pkg::beats_per_matrix - 1)) begin
                rhs_beat <= '0;
                rhs_complete <= 1'b1;
            end else begin
                rhs_beat <= rhs_beat + 1'b1;
                rhs_complete <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            compute_count <= '0;
            out_beat <= '0;
            drain_done <= 1'b0;
        end else begin
            drain_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (job_load) begin
                        state <= st_compute;
                        compute_count <= '0;
                    end
                end
                st_compute: begin
                    compute_count <= compute_count + 1'b1;
                    if (capture) begin
                        state <= st_drain;
                        out_beat <= '0;
                    end
                end
                st_drain: begin
                    if (out_ready) begin
                        if (out_last) begin
                            state <= st_idle;
                            out_beat <= '0;
                            drain_done <= 1'b1;
                        end else begin
                            out_beat <= out_beat + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/spmm_pkg.sv */
`default_nettype none

package spmm_pkg;

    // matrix geometry
    localparam int n = 8;
    localparam int data_width = 8;
    localparam int rows_per_beat = 4;
    localparam int beats_per_matrix = n / rows_per_beat;

    // reduction tree depth and total compute latency
    localparam int red_levels = $clog2(n);
    localparam int pipe_depth = red_levels + 2;

    // one matrix element, arithmetic wraps at this width
    typedef logic [data_width-1:0] data_t;

    // row or column index
    typedef logic [red_levels-1:0] idx_t;

    // nonzero count, 0 to n inclusive
    typedef logic [red_levels:0] ptr_t;

    typedef data_t [n-1:0] row_t;

    typedef row_t [rows_per_beat-1:0] beat_t;

    typedef row_t [n-1:0] matrix_t;

endpackage

`default_nettype wire

/* src/spmm_top.sv */
`default_nettype none

module spmm_top (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              rhs_valid,
    input  spmm_pkg::beat_t                   rhs_rows,
    output logic                              rhs_ready,
    input  logic                              lhs_valid,
    input  spmm_pkg::ptr_t [spmm_pkg::n-1:0]  lhs_row_end,
    input  spmm_pkg::idx_t [spmm_pkg::n-1:0]  lhs_col,
    input  spmm_pkg::data_t [spmm_pkg::n-1:0] lhs_data,
    output logic                              lhs_ready,
    output logic                              out_valid,
    output spmm_pkg::beat_t                   out_rows,
    output logic                              out_last,
    input  logic                              out_ready
);

    logic              rhs_write;
    spmm_pkg::idx_t    rhs_beat;
    logic              job_load;
    logic              capture;
    spmm_pkg::idx_t    out_beat;
    spmm_pkg::matrix_t matrix;
    spmm_pkg::matrix_t col_sums;

    lhs_job_if job ();

    spmm_ctrl ctrl0 (
        .clock     (clock),
        .reset     (reset),
        .rhs_valid (rhs_valid),
        .lhs_valid (lhs_valid),
        .out_ready (out_ready),
        .rhs_ready (rhs_ready),
        .lhs_ready (lhs_ready),
        .out_valid (out_valid),
        .out_last  (out_last),
        .rhs_write (rhs_write),
        .rhs_beat  (rhs_beat),
        .job_load  (job_load),
        .capture   (capture),
        .out_beat  (out_beat)
    );

    rhs_store store0 (
        .clock     (clock),
        .reset     (reset),
        .rhs_write (rhs_write),
        .rhs_beat  (rhs_beat),
        .rhs_rows  (rhs_rows),
        .matrix    (matrix)
    );

    segment_decoder decoder0 (
        .clock       (clock),
        .reset       (reset),
        .job_load    (job_load),
        .lhs_row_end (lhs_row_end),
        .lhs_col     (lhs_col),
        .lhs_data    (lhs_data),
        .job         (job.source)
    );

    // one processing column per result column
    for (genvar j = 0; j < spmm_pkg::n; j++) begin : g_pe
        pe_column #(
            .col_index (j)
        ) pe0 (
            .clock    (clock),
            .reset    (reset),
            .job      (job.sink),
            .matrix   (matrix),
            .row_sums (col_sums[j])
        );
    end

    result_drain drain0 (
        .clock    (clock),
        .reset    (reset),
        .capture  (capture),
        .out_beat (out_beat),
        .row_sums (col_sums),
        .out_rows (out_rows)
    );

endmodule

`default_nettype wire
